// File: Makefile
# Verilator build and run for the asymmetric FIFO

VERILATOR  ?= verilator
TOP        ?= asym_fifo_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert -Wall
PASS_MSG   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
design/asym_fifo_pkg.sv
design/asym_csr_pkg.sv
design/banked_ram.sv
design/asym_width_converter.sv
design/asym_fifo_ctrl.sv
design/asym_fifo_csr.sv
design/asym_fifo_top.sv
dv/asym_fifo_props.sv
dv/asym_fifo_tb.sv

// File: design/asym_csr_pkg.sv
/*
 * register map of the asymmetric FIFO
 * addresses, field positions, reset values and register types
 */
package asym_csr_pkg;

   localparam int CSR_ADDR_W = 2;
   localparam int CSR_DATA_W = 8;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
   typedef logic [CSR_DATA_W-1:0] csr_data_t;

   // register addresses
   localparam csr_addr_t ADDR_CTRL   = 2'd0;
   localparam csr_addr_t ADDR_THRESH = 2'd1;
   localparam csr_addr_t ADDR_STATUS = 2'd2;
   localparam csr_addr_t ADDR_LEVEL  = 2'd3;

   // CTRL fields, write only
   localparam int CTRL_CLEAR_BIT = 0;

   // STATUS fields, write 1 to clear
   localparam int STAT_OVF_BIT = 0;
   localparam int STAT_UDF_BIT = 1;

   // almost full threshold in bytes
   localparam csr_data_t THRESH_RST = 8'd48;

endpackage

// File: design/asym_fifo_csr.sv
/*
 * FIFO register block
 * threshold, sticky overflow and underflow, level readout, soft clear
 */
`timescale 1ns/1ns

module asym_fifo_csr (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   input  logic                     csr_we_i,
   input  asym_csr_pkg::csr_addr_t  csr_addr_i,
   input  asym_csr_pkg::csr_data_t  csr_wdata_i,
   output asym_csr_pkg::csr_data_t  csr_rdata_o,
   // from the controller
   input  asym_fifo_pkg::level_t    level_i,
   input  logic                     ovf_i,
   input  logic                     udf_i,
   // to the controller and outside
   output logic                     clear_o,
   output logic                     almost_full_o
);

   asym_csr_pkg::csr_data_t thresh_q;
   logic                    ovf_q;
   logic                    udf_q;
   logic                    clear_q;
   logic                    wr_ctrl;
   logic                    wr_thresh;
   logic                    wr_status;

   assign wr_ctrl   = csr_we_i && (csr_addr_i == asym_csr_pkg::ADDR_CTRL);
   assign wr_thresh = csr_we_i && (csr_addr_i == asym_csr_pkg::ADDR_THRESH);
   assign wr_status = csr_we_i && (csr_addr_i == asym_csr_pkg::ADDR_STATUS);

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         thresh_q <= asym_csr_pkg::THRESH_RST;
         ovf_q    <= 1'b0;
         udf_q    <= 1'b0;
         clear_q  <= 1'b0;
      end else begin
         // single-cycle pulse, CTRL itself stores nothing
         clear_q <= wr_ctrl && csr_wdata_i[asym_csr_pkg::CTRL_CLEAR_BIT];
         if (wr_thresh) begin
            thresh_q <= csr_wdata_i;
         end
         // a new event wins over a write-1-to-clear in the same cycle
         ovf_q <= ovf_i ||
                  (ovf_q && !(wr_status && csr_wdata_i[asym_csr_pkg::STAT_OVF_BIT]));
         udf_q <= udf_i ||
                  (udf_q && !(wr_status && csr_wdata_i[asym_csr_pkg::STAT_UDF_BIT]));
      end
   end

   assign clear_o = clear_q;

   // level and threshold are both flops, so this follows the level edge for edge
   assign almost_full_o = asym_csr_pkg::csr_data_t'(level_i) >= thresh_q;

   always_comb begin
      csr_rdata_o = '0;
      case (csr_addr_i)
         asym_csr_pkg::ADDR_THRESH: csr_rdata_o = thresh_q;
         asym_csr_pkg::ADDR_STATUS: begin
            csr_rdata_o[asym_csr_pkg::STAT_OVF_BIT] = ovf_q;
            csr_rdata_o[asym_csr_pkg::STAT_UDF_BIT] = udf_q;
         end
         asym_csr_pkg::ADDR_LEVEL:  csr_rdata_o = asym_csr_pkg::csr_data_t'(level_i);
         // CTRL reads back as zero
         default:                   csr_rdata_o = '0;
      endcase
   end

endmodule

// File: design/asym_fifo_ctrl.sv
/*
 * FIFO control for 32-bit writes and 8-bit reads
 * pointers, byte level, full and empty, strobe gating
 */
`timescale 1ns/1ns

module asym_fifo_ctrl (
   input  logic                                clk_i,
   input  logic                                rst_n_i,
   input  logic                                w_en_i,
   input  logic                                r_en_i,
   input  logic                                clear_i,
   // to the width converter
   output logic                                mem_w_en_o,
   output logic [asym_fifo_pkg::W_ADDR_W-1:0]  mem_w_addr_o,
   output logic                                mem_r_en_o,
   output logic [asym_fifo_pkg::R_ADDR_W-1:0]  mem_r_addr_o,
   // status
   output asym_fifo_pkg::level_t               level_o,
   output logic                                full_o,
   output logic                                empty_o,
   output logic                                ovf_o,
   output logic                                udf_o
);

   // top bit of each pointer is the wrap bit
   logic [asym_fifo_pkg::W_ADDR_W:0] wr_ptr_q;
   logic [asym_fifo_pkg::R_ADDR_W:0] rd_ptr_q;

   asym_fifo_pkg::level_t level_q;
   asym_fifo_pkg::level_t level_nxt;
   asym_fifo_pkg::level_t free_nxt;
   logic                  full_q;
   logic                  empty_q;
   logic                  w_acc;
   logic                  r_acc;

   assign w_acc = w_en_i && !full_q;
   assign r_acc = r_en_i && !empty_q;

   // dropped strobes
   assign ovf_o = w_en_i && full_q;
   assign udf_o = r_en_i && empty_q;

   // one word in is RATIO bytes, one read is a single byte
   always_comb begin
      level_nxt = level_q;
      if (w_acc) begin
         level_nxt = level_nxt + asym_fifo_pkg::level_t'(asym_fifo_pkg::RATIO);
      end
      if (r_acc) begin
         level_nxt = level_nxt - asym_fifo_pkg::level_t'(1);
      end
   end

   assign free_nxt = asym_fifo_pkg::level_t'(asym_fifo_pkg::FIFO_DEPTH) - level_nxt;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;
      end else if (clear_i) begin
         // soft clear drops everything stored
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         level_q  <= '0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;
      end else begin
         if (w_acc) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (r_acc) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         level_q <= level_nxt;
         // full once a whole word no longer fits
         full_q  <= free_nxt < asym_fifo_pkg::level_t'(asym_fifo_pkg::RATIO);
         empty_q <= level_nxt == '0;
      end
   end

   assign mem_w_en_o   = w_acc;
   assign mem_w_addr_o = wr_ptr_q[asym_fifo_pkg::W_ADDR_W-1:0];
   assign mem_r_en_o   = r_acc;
   assign mem_r_addr_o = rd_ptr_q[asym_fifo_pkg::R_ADDR_W-1:0];

   assign level_o = level_q;
   assign full_o  = full_q;
   assign empty_o = empty_q;

endmodule

// File: design/asym_fifo_pkg.sv
/*
 * asymmetric FIFO datapath package
 * widths, ratio, depths, byte order and payload types
 */
package asym_fifo_pkg;

   // write and read data widths
   localparam int W_DATA_W = 32;
   localparam int R_DATA_W = 8;

   // bytes per word
   localparam int RATIO      = W_DATA_W / R_DATA_W;
   localparam int BYTE_SEL_W = $clog2(RATIO);

   // byte addressing, 64 bytes deep
   localparam int R_ADDR_W   = 6;
   localparam int FIFO_DEPTH = 1 << R_ADDR_W;

   // word addressing, one row of all banks per word
   localparam int W_ADDR_W    = R_ADDR_W - BYTE_SEL_W;
   localparam int BANK_ADDR_W = W_ADDR_W;

   // level must hold 0 up to FIFO_DEPTH inclusive
   localparam int LEVEL_W = R_ADDR_W + 1;

   // 0 is little endian, 1 is big endian
   localparam bit BIG_ENDIAN = 1'b0;

   typedef logic [W_DATA_W-1:0] wdata_t;
   typedef logic [R_DATA_W-1:0] rdata_t;
   typedef logic [LEVEL_W-1:0]  level_t;

endpackage

// File: design/asym_fifo_top.sv
/*
 * asymmetric FIFO, 32-bit words in and bytes out
 * controller, registers, width converter and banked RAM
 */
`timescale 1ns/1ns

module asym_fifo_top (
   input  logic                     clk_i,
   input  logic                     rst_n_i,
   // write side
   input  logic                     w_en_i,
   input  asym_fifo_pkg::wdata_t    w_data_i,
   // read side
   input  logic                     r_en_i,
   output asym_fifo_pkg::rdata_t    r_data_o,
   output logic                     r_valid_o,
   // status
   output logic                     full_o,
   output logic                     empty_o,
   output logic                     almost_full_o,
   // registers
   input  logic                     csr_we_i,
   input  asym_csr_pkg::csr_addr_t  csr_addr_i,
   input  asym_csr_pkg::csr_data_t  csr_wdata_i,
   output asym_csr_pkg::csr_data_t  csr_rdata_o
);

   // controller to converter
   logic                                  mem_w_en;
   logic [asym_fifo_pkg::W_ADDR_W-1:0]    mem_w_addr;
   logic                                  mem_r_en;
   logic [asym_fifo_pkg::R_ADDR_W-1:0]    mem_r_addr;

   // controller and register block
   asym_fifo_pkg::level_t                 level;
   logic                                  ovf;
   logic                                  udf;
   logic                                  clear;

   // converter to RAM
   logic [asym_fifo_pkg::RATIO-1:0]       ram_w_en;
   logic [asym_fifo_pkg::BANK_ADDR_W-1:0] ram_w_addr;
   asym_fifo_pkg::wdata_t                 ram_w_data;
   logic [asym_fifo_pkg::RATIO-1:0]       ram_r_en;
   logic [asym_fifo_pkg::BANK_ADDR_W-1:0] ram_r_addr;
   asym_fifo_pkg::wdata_t                 ram_r_data;

   asym_fifo_ctrl ctrl_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .w_en_i       (w_en_i),
      .r_en_i       (r_en_i),
      .clear_i      (clear),
      .mem_w_en_o   (mem_w_en),
      .mem_w_addr_o (mem_w_addr),
      .mem_r_en_o   (mem_r_en),
      .mem_r_addr_o (mem_r_addr),
      .level_o      (level),
      .full_o       (full_o),
      .empty_o      (empty_o),
      .ovf_o        (ovf),
      .udf_o        (udf)
   );

   asym_fifo_csr csr_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .csr_we_i      (csr_we_i),
      .csr_addr_i    (csr_addr_i),
      .csr_wdata_i   (csr_wdata_i),
      .csr_rdata_o   (csr_rdata_o),
      .level_i       (level),
      .ovf_i         (ovf),
      .udf_i         (udf),
      .clear_o       (clear),
      .almost_full_o (almost_full_o)
   );

   // write data goes straight from the port to the converter
   asym_width_converter #(
      .BIG_ENDIAN (asym_fifo_pkg::BIG_ENDIAN)
   ) conv_i (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .w_en_i           (mem_w_en),
      .w_addr_i         (mem_w_addr),
      .w_data_i         (w_data_i),
      .r_en_i           (mem_r_en),
      .r_addr_i         (mem_r_addr),
      .r_data_o         (r_data_o),
      .r_valid_o        (r_valid_o),
      .ext_mem_w_en_o   (ram_w_en),
      .ext_mem_w_addr_o (ram_w_addr),
      .ext_mem_w_data_o (ram_w_data),
      .ext_mem_r_en_o   (ram_r_en),
      .ext_mem_r_addr_o (ram_r_addr),
      .ext_mem_r_data_i (ram_r_data)
   );

   banked_ram ram_i (
      .clk_i    (clk_i),
      .w_en_i   (ram_w_en),
      .w_addr_i (ram_w_addr),
      .w_data_i (ram_w_data),
      .r_en_i   (ram_r_en),
      .r_addr_i (ram_r_addr),
      .r_data_o (ram_r_data)
   );

endmodule

// File: design/asym_width_converter.sv
/*
 * write-wider width converter between FIFO control and banked RAM
 * spreads a word over all banks, reads one byte per strobe and holds it
 */
`timescale 1ns/1ns

module asym_width_converter #(
   parameter bit BIG_ENDIAN = asym_fifo_pkg::BIG_ENDIAN
) (
   input  logic                                   clk_i,
   input  logic                                   rst_n_i,
   // wide write side
   input  logic                                   w_en_i,
   input  logic [asym_fifo_pkg::W_ADDR_W-1:0]     w_addr_i,
   input  asym_fifo_pkg::wdata_t                  w_data_i,
   // narrow read side
   input  logic                                   r_en_i,
   input  logic [asym_fifo_pkg::R_ADDR_W-1:0]     r_addr_i,
   output asym_fifo_pkg::rdata_t                  r_data_o,
   output logic                                   r_valid_o,
   // banked memory
   output logic [asym_fifo_pkg::RATIO-1:0]        ext_mem_w_en_o,
   output logic [asym_fifo_pkg::BANK_ADDR_W-1:0]  ext_mem_w_addr_o,
   output asym_fifo_pkg::wdata_t                  ext_mem_w_data_o,
   output logic [asym_fifo_pkg::RATIO-1:0]        ext_mem_r_en_o,
   output logic [asym_fifo_pkg::BANK_ADDR_W-1:0]  ext_mem_r_addr_o,
   input  asym_fifo_pkg::wdata_t                  ext_mem_r_data_i
);

   logic                                    valid_q;
   logic [asym_fifo_pkg::BYTE_SEL_W-1:0]    lsb_q;
   logic [asym_fifo_pkg::BYTE_SEL_W-1:0]    rd_bank;
   logic [asym_fifo_pkg::BYTE_SEL_W-1:0]    sel_bank;
   asym_fifo_pkg::rdata_t                   hold_q;
   asym_fifo_pkg::rdata_t                   mem_byte;
   asym_fifo_pkg::rdata_t [asym_fifo_pkg::RATIO-1:0] mem_row;

   // a word lands in one row across every bank
   assign ext_mem_w_en_o   = {asym_fifo_pkg::RATIO{w_en_i}};
   assign ext_mem_w_addr_o = w_addr_i;
   assign ext_mem_w_data_o = w_data_i;

   // row from the upper byte-address bits
   assign ext_mem_r_addr_o = r_addr_i[asym_fifo_pkg::R_ADDR_W-1:asym_fifo_pkg::BYTE_SEL_W];

   // byte lane from the low bits, mirrored for big endian
   // (RATIO is a power of two, so RATIO-1-x is ~x)
   if (BIG_ENDIAN) begin : g_big_endian
      assign rd_bank  = ~r_addr_i[asym_fifo_pkg::BYTE_SEL_W-1:0];
      assign sel_bank = ~lsb_q;
   end else begin : g_little_endian
      assign rd_bank  = r_addr_i[asym_fifo_pkg::BYTE_SEL_W-1:0];
      assign sel_bank = lsb_q;
   end

   // only the addressed bank is read
   always_comb begin
      ext_mem_r_en_o          = '0;
      ext_mem_r_en_o[rd_bank] = r_en_i;
   end

   // read strobe delayed to match the RAM latency
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
         lsb_q   <= '0;
      end else begin
         valid_q <= r_en_i;
         if (r_en_i) begin
            lsb_q <= r_addr_i[asym_fifo_pkg::BYTE_SEL_W-1:0];
         end
      end
   end

   assign mem_row  = ext_mem_r_data_i;
   assign mem_byte = mem_row[sel_bank];

   // keep the last byte once the RAM output moves on
   always_ff @(posedge clk_i) begin
      if (valid_q) begin
         hold_q <= mem_byte;
      end
   end

   assign r_valid_o = valid_q;
   assign r_data_o  = valid_q ? mem_byte : hold_q;

endmodule

// File: design/banked_ram.sv
/*
 * banked dual-port RAM, one byte-wide bank per byte lane of a word
 * each bank writes and reads synchronously under its own enable
 */
`timescale 1ns/1ns

module banked_ram (
   input  logic                                    clk_i,
   // write port
   input  logic [asym_fifo_pkg::RATIO-1:0]         w_en_i,
   input  logic [asym_fifo_pkg::BANK_ADDR_W-1:0]   w_addr_i,
   input  asym_fifo_pkg::wdata_t                   w_data_i,
   // read port
   input  logic [asym_fifo_pkg::RATIO-1:0]         r_en_i,
   input  logic [asym_fifo_pkg::BANK_ADDR_W-1:0]   r_addr_i,
   output asym_fifo_pkg::wdata_t                   r_data_o
);

   // per-lane views of the wide buses
   asym_fifo_pkg::rdata_t [asym_fifo_pkg::RATIO-1:0] w_lane;
   asym_fifo_pkg::rdata_t [asym_fifo_pkg::RATIO-1:0] r_lane;

   assign w_lane   = w_data_i;
   assign r_data_o = r_lane;

   for (genvar b = 0; b < asym_fifo_pkg::RATIO; b++) begin : g_bank

      asym_fifo_pkg::rdata_t mem [2**asym_fifo_pkg::BANK_ADDR_W];
      asym_fifo_pkg::rdata_t rd_q;

      always_ff @(posedge clk_i) begin
         if (w_en_i[b]) begin
            mem[w_addr_i] <= w_lane[b];
         end
         // read-old on a same-row collision
         if (r_en_i[b]) begin
            rd_q <= mem[r_addr_i];
         end
      end

      assign r_lane[b] = rd_q;

   end

endmodule

// File: dv/asym_fifo_props.sv
/*
 * controller properties for the asymmetric FIFO
 * bound into every asym_fifo_ctrl instance
 */
`timescale 1ns/1ns

module asym_fifo_props (
   input logic                               clk_i,
   input logic                               rst_n_i,
   input logic                               w_en_i,
   input logic                               r_en_i,
   input logic                               clear_i,
   input logic [asym_fifo_pkg::W_ADDR_W:0]   wr_ptr_i,
   input logic [asym_fifo_pkg::R_ADDR_W:0]   rd_ptr_i,
   input asym_fifo_pkg::level_t              level_i,
   input logic                               full_i,
   input logic                               empty_i
);

   // failures seen so far, read back by the testbench
   int fail_cnt = 0;

   full_empty_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      !(full_i && empty_i))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("full and empty are high together");
      end

   // a write against full with no read beside it must not move the level
   dropped_write_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (w_en_i && full_i && !r_en_i && !clear_i) |=> $stable(level_i))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("level changed on a dropped write");
      end

   level_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      level_i <= asym_fifo_pkg::level_t'(asym_fifo_pkg::FIFO_DEPTH))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("level above FIFO depth");
      end

   // pointer distance in bytes, wrap bits included, equals the level
   level_ptr_match: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      level_i == asym_fifo_pkg::level_t'(
         {wr_ptr_i, {asym_fifo_pkg::BYTE_SEL_W{1'b0}}} - rd_ptr_i))
      else begin
         fail_cnt = fail_cnt + 1;
         $error("level does not match the pointer distance");
      end

endmodule

bind asym_fifo_ctrl asym_fifo_props props_i (
   .clk_i    (clk_i),
   .rst_n_i  (rst_n_i),
   .w_en_i   (w_en_i),
   .r_en_i   (r_en_i),
   .clear_i  (clear_i),
   .wr_ptr_i (wr_ptr_q),
   .rd_ptr_i (rd_ptr_q),
   .level_i  (level_o),
   .full_i   (full_o),
   .empty_i  (empty_o)
);

// File: dv/asym_fifo_tb.sv
/*
 * testbench for the asymmetric FIFO
 * byte-queue reference model, register checks and random traffic
 */
`timescale 1ns/1ns

module asym_fifo_tb;

   localparam int CLK_PERIOD  = 10;
   localparam int RAND_CYCLES = 2000;
   // strobes over all tests, sizes the watchdog
   localparam int N_STROBES   = 3 + 3 + 12 + 17 + 64 + 6 + 8 + RAND_CYCLES + 72;
   localparam int WATCHDOG_NS = (4 * N_STROBES + 200) * CLK_PERIOD;

   localparam asym_csr_pkg::csr_data_t OVF_MASK =
      asym_csr_pkg::csr_data_t'(1) << asym_csr_pkg::STAT_OVF_BIT;
   localparam asym_csr_pkg::csr_data_t UDF_MASK =
      asym_csr_pkg::csr_data_t'(1) << asym_csr_pkg::STAT_UDF_BIT;
   localparam asym_csr_pkg::csr_data_t CLEAR_MASK =
      asym_csr_pkg::csr_data_t'(1) << asym_csr_pkg::CTRL_CLEAR_BIT;

   logic                    clk;
   logic                    rst_n;
   logic                    w_en;
   asym_fifo_pkg::wdata_t   w_data;
   logic                    r_en;
   asym_fifo_pkg::rdata_t   r_data;
   logic                    r_valid;
   logic                    full;
   logic                    empty;
   logic                    almost_full;
   logic                    csr_we;
   asym_csr_pkg::csr_addr_t csr_addr;
   asym_csr_pkg::csr_data_t csr_wdata;
   asym_csr_pkg::csr_data_t csr_rdata;

   asym_fifo_pkg::rdata_t   model_q[$];
   asym_fifo_pkg::rdata_t   exp_byte;
   logic                    rd_due;
   logic                    level_watch;
   integer                  seed;
   integer                  rnd;
   string                   test_name;
   int                      errors;
   int                      checks;
   int                      err_mark;
   int                      n_tests;

   asym_fifo_top dut_i (
      .clk_i         (clk),
      .rst_n_i       (rst_n),
      .w_en_i        (w_en),
      .w_data_i      (w_data),
      .r_en_i        (r_en),
      .r_data_o      (r_data),
      .r_valid_o     (r_valid),
      .full_o        (full),
      .empty_o       (empty),
      .almost_full_o (almost_full),
      .csr_we_i      (csr_we),
      .csr_addr_i    (csr_addr),
      .csr_wdata_i   (csr_wdata),
      .csr_rdata_o   (csr_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, test_name);
      $display("sim failed");
      $finish;
   end

   // expected fill level in bytes
   function automatic asym_fifo_pkg::level_t model_level();
      return asym_fifo_pkg::level_t'(model_q.size());
   endfunction

   task automatic check_byte(input asym_fifo_pkg::rdata_t exp, input asym_fifo_pkg::rdata_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s r_data_o: expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic check_level(input asym_fifo_pkg::level_t exp,
                              input asym_fifo_pkg::level_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s level: expected %0d, actual %0d", test_name, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_csr(input string what, input asym_csr_pkg::csr_data_t exp,
                            input asym_csr_pkg::csr_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   // strobes set here are taken at the following edge
   task automatic step(input logic w, input asym_fifo_pkg::wdata_t d, input logic r);
      @(posedge clk);
      w_en   <= w;
      w_data <= d;
      r_en   <= r;
   endtask

   task automatic idle(input int n);
      repeat (n) step(1'b0, '0, 1'b0);
   endtask

   task automatic csr_write(input asym_csr_pkg::csr_addr_t a, input asym_csr_pkg::csr_data_t d);
      @(posedge clk);
      csr_we    <= 1'b1;
      csr_addr  <= a;
      csr_wdata <= d;
      @(posedge clk);
      csr_we    <= 1'b0;
   endtask

   task automatic csr_expect(input string what, input asym_csr_pkg::csr_addr_t a,
                             input asym_csr_pkg::csr_data_t exp);
      @(posedge clk);
      csr_addr <= a;
      @(negedge clk);
      check_csr(what, exp, csr_rdata);
   endtask

   task automatic level_expect();
      @(posedge clk);
      csr_addr <= asym_csr_pkg::ADDR_LEVEL;
      @(negedge clk);
      check_level(model_level(), asym_fifo_pkg::level_t'(csr_rdata));
   endtask

   task automatic begin_test(input string name);
      test_name = name;
      err_mark  = errors;
      n_tests++;
   endtask

   task automatic end_test();
      if (errors == err_mark) begin
         $display("test %s: ok", test_name);
      end else begin
         $display("test %s: %0d errors", test_name, errors - err_mark);
      end
   endtask

   // compare process, mid-cycle where every signal is stable
   always @(negedge clk) begin
      if (rst_n) begin
         check_flag("r_valid_o", rd_due, r_valid);
         if (rd_due) begin
            check_byte(exp_byte, r_data);
         end
         if (level_watch) begin
            check_level(model_level(), asym_fifo_pkg::level_t'(csr_rdata));
         end
         // predict what the next edge accepts, read before write
         rd_due = r_en && !empty;
         if (rd_due && model_q.size() == 0) begin
            errors++;
            $display("%s: DUT accepted a read while the model holds no data", test_name);
            rd_due = 1'b0;
         end else if (rd_due) begin
            exp_byte = model_q.pop_front();
         end
         if (w_en && !full) begin
            for (int b = 0; b < asym_fifo_pkg::RATIO; b++) begin
               model_q.push_back(w_data[asym_fifo_pkg::R_DATA_W*b +: asym_fifo_pkg::R_DATA_W]);
            end
         end
      end
   end

   initial begin
      seed        = 32'h54d1b595;
      errors      = 0;
      checks      = 0;
      n_tests     = 0;
      err_mark    = 0;
      rd_due      = 1'b0;
      level_watch = 1'b0;
      test_name   = "reset";
      rst_n       = 1'b0;
      w_en        = 1'b0;
      w_data      = '0;
      r_en        = 1'b0;
      csr_we      = 1'b0;
      csr_addr    = asym_csr_pkg::ADDR_CTRL;
      csr_wdata   = '0;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      idle(2);

      begin_test("empty_underflow");
      @(negedge clk);
      check_flag("empty_o", 1'b1, empty);
      check_flag("full_o", 1'b0, full);
      check_flag("almost_full_o", 1'b0, almost_full);
      csr_expect("THRESH", asym_csr_pkg::ADDR_THRESH, asym_csr_pkg::THRESH_RST);
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, 8'h00);
      level_expect();
      repeat (3) step(1'b0, '0, 1'b1);
      idle(2);
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, UDF_MASK);
      csr_write(asym_csr_pkg::ADDR_STATUS, UDF_MASK);
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, 8'h00);
      end_test();

      begin_test("byte_order");
      step(1'b1, 32'h03020100, 1'b0);
      step(1'b1, 32'h07060504, 1'b0);
      step(1'b1, 32'h0b0a0908, 1'b0);
      idle(1);
      level_expect();
      repeat (12) step(1'b0, '0, 1'b1);
      idle(3);
      // last byte stays on the output
      @(negedge clk);
      check_byte(8'h0b, r_data);
      check_flag("empty_o", 1'b1, empty);
      end_test();

      begin_test("full_overflow");
      repeat (16) step(1'b1, $random(seed), 1'b0);
      // 16th word lands on this edge, the 17th meets full
      step(1'b1, $random(seed), 1'b0);
      @(negedge clk);
      check_flag("full_o", 1'b1, full);
      idle(2);
      check_level(asym_fifo_pkg::level_t'(asym_fifo_pkg::FIFO_DEPTH), model_level());
      level_expect();
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, OVF_MASK);
      csr_write(asym_csr_pkg::ADDR_STATUS, OVF_MASK);
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, 8'h00);
      repeat (64) step(1'b0, '0, 1'b1);
      idle(3);
      level_expect();
      check_flag("empty_o", 1'b1, empty);
      end_test();

      begin_test("soft_clear");
      step(1'b0, '0, 1'b1);
      repeat (5) step(1'b1, $random(seed), 1'b0);
      idle(2);
      level_expect();
      // threshold away from its reset value, so a clear that resets it shows up
      csr_write(asym_csr_pkg::ADDR_THRESH, 8'd40);
      csr_write(asym_csr_pkg::ADDR_CTRL, CLEAR_MASK);
      idle(2);
      model_q.delete();
      level_expect();
      check_flag("empty_o", 1'b1, empty);
      csr_expect("THRESH", asym_csr_pkg::ADDR_THRESH, 8'd40);
      csr_expect("STATUS", asym_csr_pkg::ADDR_STATUS, UDF_MASK);
      csr_write(asym_csr_pkg::ADDR_STATUS, UDF_MASK);
      end_test();

      begin_test("threshold");
      csr_write(asym_csr_pkg::ADDR_THRESH, 8'd20);
      csr_expect("THRESH", asym_csr_pkg::ADDR_THRESH, 8'd20);
      for (int i = 0; i < 8; i++) begin
         step(1'b1, $random(seed), 1'b0);
         idle(1);
         @(negedge clk);
         check_flag("almost_full_o", model_level() >= asym_fifo_pkg::level_t'(20), almost_full);
      end
      end_test();

      begin_test("random");
      @(posedge clk);
      csr_addr <= asym_csr_pkg::ADDR_LEVEL;
      @(posedge clk);
      level_watch = 1'b1;
      for (int i = 0; i < RAND_CYCLES; i++) begin
         rnd = $random(seed);
         // write-heavy first half runs into full, read-heavy second half into empty
         if (i < RAND_CYCLES / 2) begin
            step(rnd[1:0] == 2'b00, $random(seed), rnd[3:2] != 2'b00);
         end else begin
            step(rnd[2:0] == 3'b000, $random(seed), rnd[5:3] != 3'b000);
         end
      end
      repeat (72) step(1'b0, '0, 1'b1);
      idle(3);
      level_watch = 1'b0;
      @(negedge clk);
      check_flag("empty_o", 1'b1, empty);
      end_test();

      errors = errors + dut_i.ctrl_i.props_i.fail_cnt;
      $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
